// File: hdl/lsq_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared sizes, opcodes and payload structs for the load/store path.
// Every stage imports this package. snoop_entry is the single place where
// an entry picks up missing operands from the two CDB ports.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package lsq_pkg;

    localparam int rob_tag_w  = 5;   // tag 0 means the value is already present
    localparam int xlen       = 32;
    localparam int reg_idx_w  = 5;
    localparam int lsb_depth  = 16;
    localparam int lsb_idx_w  = $clog2(lsb_depth);
    localparam int mem_words  = 256;
    localparam int mem_addr_w = $clog2(mem_words);

    typedef enum logic {
        op_lw,
        op_sw
    } mem_op_t;

    typedef struct packed {
        logic                 valid;
        logic [rob_tag_w-1:0] tag;
        logic [xlen-1:0]      value;
    } cdb_t;

    typedef struct packed {
        mem_op_t              op;
        logic [rob_tag_w-1:0] rob_tag;
        logic [reg_idx_w-1:0] rd;
        logic [rob_tag_w-1:0] base_tag;
        logic [xlen-1:0]      base_val;
        logic [rob_tag_w-1:0] data_tag;
        logic [xlen-1:0]      data_val;  // store data, unused by loads
        logic [xlen-1:0]      imm;
    } mem_dispatch_t;

    typedef struct packed {
        mem_dispatch_t   inst;
        logic            ea_valid;
        logic [xlen-1:0] ea;
    } lsb_entry_t;

    typedef struct packed {
        mem_op_t              op;
        logic [rob_tag_w-1:0] rob_tag;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      ea;
        logic [xlen-1:0]      data;
    } mem_issue_t;

    function automatic logic tag_hit(logic [rob_tag_w-1:0] tag, cdb_t cdb);
        return cdb.valid && (tag != '0) && (cdb.tag == tag);
    endfunction

    // the external port wins if both ports carry the same tag
    function automatic lsb_entry_t snoop_entry(lsb_entry_t e, cdb_t a, cdb_t b);
        lsb_entry_t r;
        r = e;
        if (tag_hit(e.inst.base_tag, a) || tag_hit(e.inst.base_tag, b)) begin
            r.inst.base_val = tag_hit(e.inst.base_tag, a) ? a.value : b.value;
            r.inst.base_tag = '0;
            r.ea            = r.inst.base_val + r.inst.imm;
            r.ea_valid      = 1'b1;
        end
        if (tag_hit(e.inst.data_tag, a) || tag_hit(e.inst.data_tag, b)) begin
            r.inst.data_val = tag_hit(e.inst.data_tag, a) ? a.value : b.value;
            r.inst.data_tag = '0;
        end
        return r;
    endfunction

endpackage

// File: hdl/address_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address stage in front of the load/store buffer. Holds one dispatched
// memory instruction, forms base plus immediate once the base is known and
// keeps snooping the CDB until the buffer takes the entry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module address_unit import lsq_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    input  logic          in_valid,
    output logic          in_ready,
    input  mem_dispatch_t in_inst,
    input  cdb_t          cdb_ext,
    input  cdb_t          cdb_mem,
    output logic          out_valid,
    input  logic          out_ready,
    output lsb_entry_t    out_entry
);

    logic       valid_q;
    lsb_entry_t held_q;
    lsb_entry_t fresh;

    always_comb begin
        fresh.inst     = in_inst;
        fresh.ea_valid = (in_inst.base_tag == '0);
        fresh.ea       = in_inst.base_val + in_inst.imm;
    end

    assign in_ready  = !valid_q || out_ready;  // acts as a one-deep pipeline register
    assign out_valid = valid_q;
    assign out_entry = held_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            valid_q <= 1'b1;
        end else if (out_ready) begin
            valid_q <= 1'b0;
        end
    end

    // a broadcast in the dispatch cycle is caught on the way in
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held_q <= snoop_entry(fresh, cdb_ext, cdb_mem);
        end else begin
            held_q <= snoop_entry(held_q, cdb_ext, cdb_mem);
        end
    end

    hold_until_taken: assert property (@(posedge clk) disable iff (rst || flush)
        out_valid && !out_ready |=> out_valid && $stable(out_entry.inst.rob_tag));

endmodule

// File: hdl/ld_st_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// In-order load/store buffer, 16 entries in a circular array.
// Entries wait here until both operands are known, picking them up from
// either CDB port, and leave strictly from the head towards the memory
// unit. A flush from the reorder buffer empties it in one cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ld_st_buffer import lsq_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       in_valid,
    output logic       in_ready,
    input  lsb_entry_t in_entry,
    input  cdb_t       cdb_ext,
    input  cdb_t       cdb_mem,
    output logic       issue_valid,
    input  logic       issue_ready,
    output mem_issue_t issue
);

    lsb_entry_t           slots [lsb_depth];
    logic [lsb_depth-1:0] busy;
    logic [lsb_idx_w-1:0] start_idx;
    logic [lsb_idx_w-1:0] end_idx;

    logic       issue_valid_q;
    mem_issue_t issue_q;

    logic       wr_en;
    logic       head_ready;
    logic       issue_fire;
    lsb_entry_t head;

    // the tail slot is still busy only when the buffer has wrapped round
    assign in_ready = !busy[end_idx];
    assign wr_en    = in_valid && in_ready;

    assign head       = slots[start_idx];
    assign head_ready = busy[start_idx]
                        && (head.inst.base_tag == '0)
                        && (head.inst.data_tag == '0);
    // a held issue that has not transferred blocks the next one
    assign issue_fire = head_ready && (!issue_valid_q || issue_ready);

    assign issue_valid = issue_valid_q;
    assign issue       = issue_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy          <= '0;
            start_idx     <= '0;
            end_idx       <= '0;
            issue_valid_q <= 1'b0;
        end else if (flush) begin
            busy          <= '0;
            start_idx     <= '0;
            end_idx       <= '0;
            issue_valid_q <= 1'b0;  // also drops an issue still waiting for ready
        end else begin
            if (issue_valid_q && issue_ready) begin
                issue_valid_q <= 1'b0;
            end
            if (issue_fire) begin
                issue_valid_q    <= 1'b1;
                busy[start_idx]  <= 1'b0;
                start_idx        <= start_idx + 1'b1;
            end
            if (wr_en) begin
                busy[end_idx] <= 1'b1;
                end_idx       <= end_idx + 1'b1;
            end
        end
    end

    // wakeup over every slot, an incoming entry is snooped as it is written
    always_ff @(posedge clk) begin
        for (int i = 0; i < lsb_depth; i++) begin
            if (wr_en && (end_idx == lsb_idx_w'(i))) begin
                slots[i] <= snoop_entry(in_entry, cdb_ext, cdb_mem);
            end else begin
                slots[i] <= snoop_entry(slots[i], cdb_ext, cdb_mem);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            issue_q.op      <= head.inst.op;
            issue_q.rob_tag <= head.inst.rob_tag;
            issue_q.rd      <= head.inst.rd;
            issue_q.ea      <= head.ea;
            issue_q.data    <= head.inst.data_val;
        end
    end

    // the tail only lands on a busy slot when head and tail meet
    tail_slot_free: assert property (@(posedge clk) disable iff (rst)
        (end_idx != start_idx) |-> !busy[end_idx]);

    // an entry leaves only once its address was formed upstream or by a capture
    issue_operands_known: assert property (@(posedge clk) disable iff (rst || flush)
        issue_fire |-> head.ea_valid);

endmodule

// File: hdl/data_memory_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word-addressed data memory behind the load/store buffer.
// Stores write at the accept edge. Loads read at the accept edge and put
// their result on the memory CDB port one cycle later, for one cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module data_memory_unit import lsq_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    output logic       req_ready,
    input  mem_issue_t req,
    output cdb_t       cdb_mem
);

    logic [xlen-1:0] mem [mem_words];

    logic                  accept;
    logic                  ld_accept;
    logic [mem_addr_w-1:0] word_addr;

    logic                 pend_q;
    logic [rob_tag_w-1:0] pend_tag_q;
    logic [xlen-1:0]      pend_data_q;

    logic                 cdb_valid_q;
    logic [rob_tag_w-1:0] cdb_tag_q;
    logic [xlen-1:0]      cdb_value_q;

    assign req_ready = !pend_q;  // one load result in flight at a time
    assign accept    = req_valid && req_ready;
    assign ld_accept = accept && (req.op == op_lw);
    assign word_addr = req.ea[mem_addr_w+1:2];  // upper address bits wrap

    assign cdb_mem = '{valid: cdb_valid_q, tag: cdb_tag_q, value: cdb_value_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (accept && (req.op == op_sw)) begin
            mem[word_addr] <= req.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_q      <= 1'b0;
            cdb_valid_q <= 1'b0;
        end else begin
            pend_q      <= ld_accept;
            cdb_valid_q <= pend_q;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_accept) begin
            pend_tag_q  <= req.rob_tag;
            pend_data_q <= mem[word_addr];
        end
        cdb_tag_q   <= pend_tag_q;
        cdb_value_q <= pend_data_q;
    end

    // a load result stays on the memory port for one cycle only
    one_pulse_per_load: assert property (@(posedge clk) disable iff (rst)
        cdb_mem.valid |=> !cdb_mem.valid);

endmodule

// File: hdl/ld_st_subsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the load/store path: address unit, load/store buffer and data
// memory in series. The memory CDB port is fed back into both upstream
// stages next to the external port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ld_st_subsystem import lsq_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    input  logic          dispatch_valid,
    output logic          dispatch_ready,
    input  mem_dispatch_t dispatch,
    input  cdb_t          cdb_ext,
    output cdb_t          cdb_mem
);

    logic       au_valid;
    logic       au_ready;
    lsb_entry_t au_entry;

    logic       iss_valid;
    logic       iss_ready;
    mem_issue_t iss;

    address_unit au0 (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (dispatch_valid),
        .in_ready  (dispatch_ready),
        .in_inst   (dispatch),
        .cdb_ext   (cdb_ext),
        .cdb_mem   (cdb_mem),
        .out_valid (au_valid),
        .out_ready (au_ready),
        .out_entry (au_entry)
    );

    ld_st_buffer lsb0 (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .in_valid    (au_valid),
        .in_ready    (au_ready),
        .in_entry    (au_entry),
        .cdb_ext     (cdb_ext),
        .cdb_mem     (cdb_mem),
        .issue_valid (iss_valid),
        .issue_ready (iss_ready),
        .issue       (iss)
    );

    data_memory_unit dmu0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (iss_valid),
        .req_ready (iss_ready),
        .req       (iss),
        .cdb_mem   (cdb_mem)
    );

endmodule

// File: testbench/ld_st_vectors.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stimulus table for the load/store testbench, one dispatch cycle per row.
// Included inside the testbench module, after the lsq_pkg import.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam int n_rows = 25;

typedef struct {
    int                   test;
    mem_op_t              op;
    logic [rob_tag_w-1:0] rob;    // 0 means no dispatch in this row
    logic [rob_tag_w-1:0] btag;
    logic [xlen-1:0]      bval;
    logic [rob_tag_w-1:0] dtag;
    logic [xlen-1:0]      dval;
    logic [xlen-1:0]      imm;
    logic [rob_tag_w-1:0] etag;   // external broadcast, 0 means none
    logic [xlen-1:0]      eval;
    bit                   flush;
    bit                   kill;   // cancelled by a later flush
    int                   rep;    // repeats step imm by 4 and a load's rob tag by 1
    bit                   stall;  // dispatch_ready must be low on the first try
    logic [xlen-1:0]      want;   // load result
} vec_t;

// test, op, rob, btag, bval, dtag, dval, imm, etag, eval, flush, kill, rep, stall, want
vec_t vecs [n_rows] = '{
    '{1, op_sw, 30,  0, 'h100,  0, 'ha5a50001,   0,  0, 'h0,       0, 0,  1, 0, 'h0},
    '{1, op_sw, 30,  0, 'h100,  0, 'ha5a50002,   4,  0, 'h0,       0, 0,  1, 0, 'h0},
    '{1, op_lw,  1,  0, 'h100,  0, 'h0,          0,  0, 'h0,       0, 0,  1, 0, 'ha5a50001},
    '{1, op_lw,  2,  0, 'h100,  0, 'h0,          4,  0, 'h0,       0, 0,  1, 0, 'ha5a50002},
    // the load behind the blocked store must wait for tag 3 as well
    '{2, op_sw, 30,  0, 'h200,  3, 'h0,          0,  0, 'h0,       0, 0,  1, 0, 'h0},
    '{2, op_lw,  4,  0, 'h100,  0, 'h0,          0,  0, 'h0,       0, 0,  1, 0, 'ha5a50001},
    '{2, op_lw,  0,  0, 'h0,    0, 'h0,          0,  0, 'h0,       0, 0,  4, 0, 'h0},
    '{2, op_lw,  0,  0, 'h0,    0, 'h0,          0,  3, 'hbeef0003, 0, 0,  1, 0, 'h0},
    '{2, op_lw,  5,  0, 'h200,  0, 'h0,          0,  0, 'h0,       0, 0,  1, 0, 'hbeef0003},
    '{3, op_sw, 30,  0, 'h100,  0, 'h33330008,   8,  0, 'h0,       0, 0,  1, 0, 'h0},
    '{3, op_lw,  7,  6, 'h0,    0, 'h0,          8,  0, 'h0,       0, 0,  1, 0, 'h33330008},
    '{3, op_lw,  0,  0, 'h0,    0, 'h0,          0,  0, 'h0,       0, 0,  3, 0, 'h0},
    '{3, op_lw,  0,  0, 'h0,    0, 'h0,          0,  6, 'h100,     0, 0,  1, 0, 'h0},
    // store data comes from the load with rob tag 8
    '{4, op_lw,  8,  0, 'h200,  0, 'h0,          0,  0, 'h0,       0, 0,  1, 0, 'hbeef0003},
    '{4, op_sw, 30,  0, 'h120,  8, 'h0,          0,  0, 'h0,       0, 0,  1, 0, 'h0},
    '{4, op_lw,  9,  0, 'h120,  0, 'h0,          0,  0, 'h0,       0, 0,  1, 0, 'hbeef0003},
    // 17 blocked stores fill the address unit and all 16 buffer slots
    '{5, op_sw, 30,  0, 'h300, 10, 'h0,          0,  0, 'h0,       0, 0, 17, 0, 'h0},
    '{5, op_lw, 11,  0, 'h300,  0, 'h0,          0, 10, 'h5555aaaa, 0, 0,  1, 1, 'h5555aaaa},
    '{5, op_lw, 12,  0, 'h300,  0, 'h0,       'h40,  0, 'h0,       0, 0,  1, 0, 'h5555aaaa},
    '{6, op_lw, 13, 14, 'h0,    0, 'h0,          0,  0, 'h0,       0, 1,  1, 0, 'h0},
    '{6, op_sw, 30,  0, 'h100,  0, 'hdead0000,   0,  0, 'h0,       0, 1,  1, 0, 'h0},
    '{6, op_lw, 15,  0, 'h100,  0, 'h0,          0,  0, 'h0,       0, 1,  1, 0, 'h0},
    '{6, op_lw,  0,  0, 'h0,    0, 'h0,          0,  0, 'h0,       1, 0,  1, 0, 'h0},
    '{6, op_lw, 16,  0, 'h100,  0, 'h0,          0,  0, 'h0,       0, 0,  1, 0, 'ha5a50001},
    '{6, op_lw, 17,  0, 'h120,  0, 'h0,          0,  0, 'h0,       0, 0,  1, 0, 'hbeef0003}
};

// File: testbench/ld_st_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the load/store subsystem. Plays the table row by row,
// predicts load results with a program-order reference memory and checks
// every memory CDB pulse in order against those predictions.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ld_st_tb import lsq_pkg::*;;

    typedef struct {
        logic [rob_tag_w-1:0] tag;
        logic [xlen-1:0]      value;
        int                   gate;  // last table row whose broadcast this load waits on
        int                   test;
    } exp_t;

    `include "ld_st_vectors.svh"

    logic          clk;
    logic          rst;
    logic          flush;
    logic          dispatch_valid;
    logic          dispatch_ready;
    mem_dispatch_t dispatch;
    cdb_t          cdb_ext;
    cdb_t          cdb_mem;

    exp_t  exp_q [$];
    int    errs [1:6];
    string names [1:6] = '{"stores then loads", "store waits on data tag",
                           "load waits on base tag", "store data from a load",
                           "full buffer back-pressure", "flush of pending entries"};
    int    last_row_done = -1;  // newest table row already taken in by the DUT
    int    cur_test = 1;
    int    checked = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    cycles = 0;
    int    total;

    ld_st_subsystem dut0 (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch       (dispatch),
        .cdb_ext        (cdb_ext),
        .cdb_mem        (cdb_mem)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // loads must come back in program order, so the queue front is always next
    function automatic void build_expectations();
        logic [xlen-1:0] ref_mem [mem_words];
        logic [xlen-1:0] tag_val [32];
        int              ext_row [32];
        int              gate;
        vec_t            v;
        logic [xlen-1:0] base;
        logic [xlen-1:0] data;
        logic [xlen-1:0] ea;
        exp_t            e;
        gate = 0;
        foreach (ref_mem[i]) ref_mem[i] = '0;
        foreach (ext_row[i]) ext_row[i] = 0;
        for (int r = 0; r < n_rows; r++) begin
            if (vecs[r].etag != 0) begin
                tag_val[vecs[r].etag] = vecs[r].eval;
                ext_row[vecs[r].etag] = r;
            end
        end
        for (int r = 0; r < n_rows; r++) begin
            v = vecs[r];
            for (int k = 0; k < v.rep; k++) begin
                if (v.rob != 0 && !v.kill) begin
                    base = (v.btag != 0) ? tag_val[v.btag] : v.bval;
                    data = (v.dtag != 0) ? tag_val[v.dtag] : v.dval;
                    ea   = base + v.imm + xlen'(4 * k);
                    if (v.btag != 0 && ext_row[v.btag] > gate) gate = ext_row[v.btag];
                    if (v.dtag != 0 && ext_row[v.dtag] > gate) gate = ext_row[v.dtag];
                    if (v.op == op_sw) begin
                        ref_mem[ea[mem_addr_w+1:2]] = data;
                    end else begin
                        e.tag   = v.rob + rob_tag_w'(k);
                        e.value = ref_mem[ea[mem_addr_w+1:2]];
                        e.gate  = gate;
                        e.test  = v.test;
                        tag_val[e.tag] = e.value;
                        if (e.value !== v.want) begin
                            $display("table row %0d expects %h but the reference memory holds %h",
                                     r, v.want, e.value);
                            errs[v.test]++;
                        end
                        exp_q.push_back(e);
                    end
                end
            end
        end
    endfunction

    function automatic mem_dispatch_t make_dispatch(vec_t v, int k);
        mem_dispatch_t d;
        d.op       = v.op;
        d.rob_tag  = (v.op == op_lw) ? v.rob + rob_tag_w'(k) : v.rob;
        d.rd       = d.rob_tag;
        d.base_tag = v.btag;
        d.base_val = v.bval;
        d.data_tag = v.dtag;
        d.data_val = v.dval;
        d.imm      = v.imm + xlen'(4 * k);
        return d;
    endfunction

    task automatic apply_row(int r, int k);
        vec_t v;
        v = vecs[r];
        @(negedge clk);
        flush          = v.flush;
        cdb_ext        = '{valid: (v.etag != 0), tag: v.etag, value: v.eval};
        dispatch_valid = (v.rob != 0);
        dispatch       = make_dispatch(v, k);
        if (v.stall && k == 0 && dispatch_ready) begin
            $display("dispatch_ready stayed high at %0t although the buffer was full", $time);
            errs[v.test]++;
        end
        while (dispatch_valid && !dispatch_ready) begin
            @(negedge clk);
            flush   = 1'b0;  // broadcast and flush go out once only
            cdb_ext = '0;
        end
        @(posedge clk);
        last_row_done = r;
    endtask

    task automatic finish_test();
        @(negedge clk);
        dispatch_valid = 1'b0;
        dispatch       = '0;
        cdb_ext        = '0;
        flush          = 1'b0;
        while (exp_q.size() != 0 && exp_q[0].test == cur_test) @(negedge clk);
        $display("test %0d (%s) done, %0d errors", cur_test, names[cur_test], errs[cur_test]);
        tests_run++;
        if (errs[cur_test] != 0) tests_failed++;
    endtask

    task automatic check_pulse();
        exp_t e;
        if (exp_q.size() == 0) begin
            $display("unexpected cdb_mem pulse at %0t with tag %0d, no load is outstanding",
                     $time, cdb_mem.tag);
            errs[cur_test]++;
        end else begin
            e = exp_q.pop_front();
            checked++;
            if (cdb_mem.tag !== e.tag || cdb_mem.value !== e.value) begin
                $display("MISMATCH at %0t: cdb_mem tag %0d value %h, expected tag %0d value %h",
                         $time, cdb_mem.tag, cdb_mem.value, e.tag, e.value);
                errs[cur_test]++;
            end
            if (last_row_done < e.gate) begin
                $display("load tag %0d finished at %0t before its operand was broadcast",
                         e.tag, $time);
                errs[cur_test]++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst && cdb_mem.valid) check_pulse();
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > n_rows * 20) begin
            $display("timeout after %0d cycles with %0d load results still missing",
                     cycles, exp_q.size());
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        rst            = 1'b1;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        cdb_ext        = '0;
        foreach (errs[i]) errs[i] = 0;
        build_expectations();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        cur_test = vecs[0].test;
        for (int r = 0; r < n_rows; r++) begin
            if (vecs[r].test != cur_test) begin
                finish_test();
                cur_test = vecs[r].test;
            end
            for (int k = 0; k < vecs[r].rep; k++) apply_row(r, k);
        end
        finish_test();
        total = 0;
        foreach (errs[i]) total += errs[i];
        $display("summary: %0d tests, %0d failed, %0d load results checked, %0d errors",
                 tests_run, tests_failed, checked, total);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+testbench
hdl/lsq_pkg.sv
hdl/address_unit.sv
hdl/ld_st_buffer.sv
hdl/data_memory_unit.sv
hdl/ld_st_subsystem.sv
testbench/ld_st_tb.sv
